//--- src/vec_settings.svh
`ifndef VEC_SETTINGS_SVH
`define VEC_SETTINGS_SVH

////////////////////////////////////////////////////////////
// register file geometry
////////////////////////////////////////////////////////////

// number of architectural vector registers, v0 doubles as mask
`define V_REGS      32

// bits per register, one load beat is one full register
`define VLEN        128

// register number width, log2 of V_REGS
`define V_ADDR_W    5

// element index width is fixed at 5 bits in the ports,
// enough for 16 elements at sew 8 plus an out of range bit

`endif

//--- src/vec_pkg.sv
package vec_pkg;

    `include "vec_settings.svh"

    ////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {sew_8, sew_16, sew_32} sew_e;    // element width
    typedef enum logic [1:0] {lmul_1, lmul_2, lmul_4} lmul_e;  // group size in regs

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_min                          // unsigned minimum
    } alu_op_e;

    typedef enum logic {wr_reg, wr_elem} wr_kind_e;             // whole reg or one slice

    typedef enum logic [1:0] {arb_idle, arb_ack, arb_release} arb_state_e;

    ////////////////////////////////////////////////////////////
    // data
    ////////////////////////////////////////////////////////////

    typedef logic [`VLEN-1:0] vreg_t;   // one full register
    typedef logic [31:0]      elem_t;   // one element, zero extended below 32

    // low sew bits set, used for slicing and truncation
    function automatic elem_t sew_ones(sew_e s);
        case (s)
            sew_8:   return 32'h0000_00ff;
            sew_16:  return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

endpackage

//--- src/vrf_wr_if.sv
`timescale 1ns/1ps
`include "vec_settings.svh"

// one write request from a peer towards the arbiter
// four-phase: req up with payload stable, ack up on the write cycle,
// req down after ack, ack down after req
interface vrf_wr_if import vec_pkg::*; ();

    logic                   req;    // requester side
    logic                   ack;    // arbiter side, high from the write cycle on
    wr_kind_e               kind;   // whole register or element
    logic [`V_ADDR_W-1:0]   addr;   // target register
    logic [4:0]             idx;    // element index, ignored for wr_reg
    vreg_t                  data;   // element sits in the low sew bits

    modport requester (
        output req,
        output kind,
        output addr,
        output idx,
        output data,
        input  ack
    );

    modport arbiter (
        input  req,
        input  kind,
        input  addr,
        input  idx,
        input  data,
        output ack
    );

endinterface

//--- src/v_regfile.sv
`timescale 1ns/1ps
`include "vec_settings.svh"

module v_regfile import vec_pkg::*; (
    input  logic                    clk,
    input  logic                    nrst,
    input  sew_e                    sew,

    // single write port, owned by the arbiter
    input  logic                    wr_en,
    input  wr_kind_e                wr_kind,
    input  logic [`V_ADDR_W-1:0]    wr_addr,
    input  logic [4:0]              wr_idx,
    input  vreg_t                   wr_data,

    // element reads for the alu, same index on both sources
    input  logic [`V_ADDR_W-1:0]    el_rd_addr_1,
    input  logic [`V_ADDR_W-1:0]    el_rd_addr_2,
    input  logic [4:0]              el_addr,
    output elem_t                   el_data_out_1,
    output elem_t                   el_data_out_2,
    output vreg_t                   mask,           // always v0

    // whole register read, outside port
    input  logic [`V_ADDR_W-1:0]    rd_reg,
    output vreg_t                   rd_data
);

    vreg_t          regs [`V_REGS];

    logic [9:0]     wr_sh;      // bit offset of the element being written
    logic [9:0]     rd_sh;      // bit offset of the elements being read
    vreg_t          wr_msk;     // ones over the target slice
    vreg_t          wr_merge;   // element write result for the whole register

    // element index to bit offset, wide enough that idx 31 at sew 32
    // still shifts everything out instead of wrapping
    function automatic logic [9:0] bit_off(sew_e s, logic [4:0] idx);
        case (s)
            sew_8:   return {2'b00, idx, 3'b000};
            sew_16:  return {1'b0, idx, 4'b0000};
            default: return {idx, 5'b00000};
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////

    always_comb begin
        wr_sh    = bit_off(sew, wr_idx);
        wr_msk   = vreg_t'(sew_ones(sew)) << wr_sh;     // zero when idx out of range
        // keep everything outside the slice, drop data bits above sew
        wr_merge = (regs[wr_addr] & ~wr_msk) | ((wr_data << wr_sh) & wr_msk);
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            for (int i = 0; i < `V_REGS; i++) begin
                regs[i] <= '0;                          // all registers start at zero
            end
        end else if (wr_en) begin
            if (wr_kind == wr_reg) begin
                regs[wr_addr] <= wr_data;               // load beat, full replace
            end else begin
                regs[wr_addr] <= wr_merge;              // alu result, one slice
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read side, all combinational
    ////////////////////////////////////////////////////////////

    assign rd_sh = bit_off(sew, el_addr);

    // shift the slice down, cut to 32 bits, clear above sew
    assign el_data_out_1 = elem_t'(regs[el_rd_addr_1] >> rd_sh) & sew_ones(sew);
    assign el_data_out_2 = elem_t'(regs[el_rd_addr_2] >> rd_sh) & sew_ones(sew);

    assign mask    = regs[0];       // v0 holds the mask bits
    assign rd_data = regs[rd_reg];  // write visible the cycle after wr_en

endmodule

//--- src/vrf_arbiter.sv
`timescale 1ns/1ps
`include "vec_settings.svh"

module vrf_arbiter import vec_pkg::*; (
    input  logic                    clk,
    input  logic                    nrst,

    vrf_wr_if.arbiter               ld,     // loader peer
    vrf_wr_if.arbiter               alu,    // element alu peer

    // shared write port of the register file
    output logic                    wr_en,
    output wr_kind_e                wr_kind,
    output logic [`V_ADDR_W-1:0]    wr_addr,
    output logic [4:0]              wr_idx,
    output vreg_t                   wr_data
);

    arb_state_e     state;
    logic           sel_alu;    // current or last owner, 1 = alu, doubles as round-robin memory
    logic           pick_alu;   // choice made in idle
    logic           gnt_ld;
    logic           gnt_alu;
    logic           owner_req;  // req of whoever holds the port

    // alu wins if alone, or if both ask and the loader went last
    assign pick_alu  = alu.req && (!ld.req || !sel_alu);
    assign owner_req = sel_alu ? alu.req : ld.req;

    ////////////////////////////////////////////////////////////
    // grant fsm
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state    <= arb_idle;
            sel_alu  <= 1'b0;
        end else begin
            case (state)
                arb_idle: begin
                    if (ld.req || alu.req) begin
                        sel_alu  <= pick_alu;
                        state    <= arb_ack;        // write happens next cycle
                    end
                end
                arb_ack: state <= arb_release;      // single write cycle
                arb_release: begin
                    if (!owner_req) state <= arb_idle;  // drop ack once req is gone
                end
                default: state <= arb_idle;
            endcase
        end
    end

    // ack stays up from the write cycle until the owner lets go
    assign gnt_ld  = (state != arb_idle) && !sel_alu;
    assign gnt_alu = (state != arb_idle) && sel_alu;
    assign ld.ack  = gnt_ld;
    assign alu.ack = gnt_alu;

    assign wr_en = (state == arb_ack);  // exactly one pulse per grant

    // owner payload onto the regfile port, only sampled while wr_en
    always_comb begin
        if (sel_alu) begin
            wr_kind = alu.kind;
            wr_addr = alu.addr;
            wr_idx  = alu.idx;
            wr_data = alu.data;
        end else begin
            wr_kind = ld.kind;
            wr_addr = ld.addr;
            wr_idx  = ld.idx;
            wr_data = ld.data;
        end
    end

endmodule

//--- src/vec_loader.sv
`timescale 1ns/1ps
`include "vec_settings.svh"

module vec_loader import vec_pkg::*; (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    ld_req,
    output logic                    ld_ack,
    input  logic                    ld_first,   // first beat of a group
    input  logic [`V_ADDR_W-1:0]    ld_reg,     // group base, aligned
    input  lmul_e                   ld_lmul,
    input  vreg_t                   ld_data,
    vrf_wr_if.requester             wr
);

    logic [`V_ADDR_W-1:0]   base;       // group base from the first beat
    logic [2:0]             grp_len;    // registers in the group
    logic [2:0]             cnt;        // next beat number
    logic [`V_ADDR_W-1:0]   beat_addr;
    logic                   beat_ok;    // beat falls inside the group
    logic                   start;

    function automatic logic [2:0] grp_size(lmul_e m);
        case (m)
            lmul_2:  return 3'd2;
            lmul_4:  return 3'd4;
            default: return 3'd1;
        endcase
    endfunction

    // new beat only when both handshakes are fully back to idle
    assign start     = ld_req && !ld_ack && !wr.req && !wr.ack;
    assign beat_addr = ld_first ? ld_reg : base + `V_ADDR_W'(cnt);
    assign beat_ok   = ld_first || (cnt < grp_len);

    assign wr.kind = wr_reg;    // always whole registers
    assign wr.idx  = '0;

    ////////////////////////////////////////////////////////////
    // handshake control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!nrst) begin
            wr.req  <= 1'b0;
            ld_ack  <= 1'b0;
            cnt     <= '0;
            grp_len <= '0;      // stray beats before any group are refused
        end else begin
            if (start && ld_first) begin
                grp_len <= grp_size(ld_lmul);
                cnt     <= '0;
            end
            if (start) begin
                if (beat_ok) wr.req <= 1'b1;    // hand the beat to the arbiter
                else         ld_ack <= 1'b1;    // refused, no write
            end
            if (wr.req && wr.ack) begin         // beat is in the regfile now
                wr.req <= 1'b0;
                ld_ack <= 1'b1;
                cnt    <= cnt + 3'd1;
            end
            if (ld_ack && !ld_req) ld_ack <= 1'b0;
        end
    end

    // payload, held while wr.req is up
    always_ff @(posedge clk) begin
        if (start && ld_first) base <= ld_reg;
        if (start && beat_ok) begin
            wr.addr <= beat_addr;
            wr.data <= ld_data;
        end
    end

endmodule

//--- src/vec_elem_alu.sv
`timescale 1ns/1ps
`include "vec_settings.svh"

module vec_elem_alu import vec_pkg::*; (
    input  logic                    clk,
    input  logic                    nrst,
    input  sew_e                    sew,
    input  logic                    op_req,
    output logic                    op_ack,
    input  alu_op_e                 op_code,
    input  logic [`V_ADDR_W-1:0]    op_vd,
    input  logic [`V_ADDR_W-1:0]    op_vs1,
    input  logic [`V_ADDR_W-1:0]    op_vs2,
    input  logic [4:0]              op_idx,
    input  logic                    op_masked,
    input  elem_t                   src_a,      // element of vs1 from the regfile
    input  elem_t                   src_b,      // element of vs2
    input  vreg_t                   mask,       // v0
    output logic [`V_ADDR_W-1:0]    src_reg_a,
    output logic [`V_ADDR_W-1:0]    src_reg_b,
    output logic [4:0]              src_idx,
    vrf_wr_if.requester             wr
);

    alu_op_e                code_q;
    logic [`V_ADDR_W-1:0]   vd_q, vs1_q, vs2_q;
    logic [4:0]             idx_q;
    elem_t                  res;
    elem_t                  res_q;
    logic                   exec;       // operands being read this cycle
    logic                   start;
    logic                   masked_off;

    assign start      = op_req && !op_ack && !exec && !wr.req && !wr.ack;
    assign masked_off = op_masked && !mask[op_idx]; // v0 bit idx is zero

    // operand reads follow the latched command
    assign src_reg_a = vs1_q;
    assign src_reg_b = vs2_q;
    assign src_idx   = idx_q;

    ////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (code_q)
            op_add:  res = src_a + src_b;
            op_sub:  res = src_a - src_b;
            op_and:  res = src_a & src_b;
            op_or:   res = src_a | src_b;
            op_xor:  res = src_a ^ src_b;
            op_min:  res = (src_a < src_b) ? src_a : src_b;  // both zero extended
            default: res = '0;
        endcase
        res = res & sew_ones(sew);  // carry and borrow above sew dropped
    end

    assign wr.kind = wr_elem;
    assign wr.addr = vd_q;
    assign wr.idx  = idx_q;
    assign wr.data = vreg_t'(res_q);    // element in the low bits

    ////////////////////////////////////////////////////////////
    // handshake control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!nrst) begin
            exec   <= 1'b0;
            wr.req <= 1'b0;
            op_ack <= 1'b0;
        end else begin
            if (start) begin
                if (masked_off) op_ack <= 1'b1;     // nothing to write
                else            exec   <= 1'b1;
            end
            if (exec) begin
                exec   <= 1'b0;
                wr.req <= 1'b1;                     // result ready in res_q
            end
            if (wr.req && wr.ack) begin
                wr.req <= 1'b0;
                op_ack <= 1'b1;                     // element written
            end
            if (op_ack && !op_req) op_ack <= 1'b0;
        end
    end

    // command and result, stable while wr.req is up
    always_ff @(posedge clk) begin
        if (start) begin
            code_q <= op_code;
            vd_q   <= op_vd;
            vs1_q  <= op_vs1;
            vs2_q  <= op_vs2;
            idx_q  <= op_idx;
        end
        if (exec) res_q <= res;
    end

endmodule

//--- src/vec_lane_top.sv
`timescale 1ns/1ps
`include "vec_settings.svh"

module vec_lane_top import vec_pkg::*; (
    input  logic                    clk,
    input  logic                    nrst,
    input  sew_e                    sew,        // change only with both req low

    // group load port
    input  logic                    ld_req,
    output logic                    ld_ack,
    input  logic                    ld_first,
    input  logic [`V_ADDR_W-1:0]    ld_reg,
    input  lmul_e                   ld_lmul,
    input  vreg_t                   ld_data,

    // element op port
    input  logic                    op_req,
    output logic                    op_ack,
    input  alu_op_e                 op_code,
    input  logic [`V_ADDR_W-1:0]    op_vd,
    input  logic [`V_ADDR_W-1:0]    op_vs1,
    input  logic [`V_ADDR_W-1:0]    op_vs2,
    input  logic [4:0]              op_idx,
    input  logic                    op_masked,

    // whole register read
    input  logic [`V_ADDR_W-1:0]    rd_reg,
    output vreg_t                   rd_data
);

    vrf_wr_if ld_wr ();     // loader to arbiter
    vrf_wr_if alu_wr ();    // alu to arbiter

    logic                   wr_en;
    wr_kind_e               wr_kind;
    logic [`V_ADDR_W-1:0]   wr_addr;
    logic [4:0]             wr_idx;
    vreg_t                  wr_data;
    logic [`V_ADDR_W-1:0]   src_reg_a, src_reg_b;
    logic [4:0]             src_idx;
    elem_t                  src_a, src_b;
    vreg_t                  mask;

    vec_loader vec_loader_inst (
        .clk, .nrst, .ld_req, .ld_ack, .ld_first, .ld_reg, .ld_lmul, .ld_data,
        .wr (ld_wr.requester)
    );

    vec_elem_alu vec_elem_alu_inst (
        .clk, .nrst, .sew, .op_req, .op_ack, .op_code, .op_vd, .op_vs1, .op_vs2,
        .op_idx, .op_masked, .src_a, .src_b, .mask, .src_reg_a, .src_reg_b,
        .src_idx, .wr (alu_wr.requester)
    );

    vrf_arbiter vrf_arbiter_inst (
        .clk, .nrst, .ld (ld_wr.arbiter), .alu (alu_wr.arbiter),
        .wr_en, .wr_kind, .wr_addr, .wr_idx, .wr_data
    );

    v_regfile v_regfile_inst (
        .clk, .nrst, .sew, .wr_en, .wr_kind, .wr_addr, .wr_idx, .wr_data,
        .el_rd_addr_1 (src_reg_a), .el_rd_addr_2 (src_reg_b), .el_addr (src_idx),
        .el_data_out_1 (src_a), .el_data_out_2 (src_b), .mask, .rd_reg, .rd_data
    );

endmodule

//--- verif/vec_lane_props.sv
`timescale 1ns/1ps
`include "vec_settings.svh"

module vec_lane_props import vec_pkg::*; (
    input  logic                            clk,
    input  logic                            nrst,
    input  logic                            ld_req,
    input  logic                            ld_ack,
    input  logic [`VLEN+`V_ADDR_W+5:0]      ld_pay,     // kind, addr, idx, data
    input  logic                            alu_req,
    input  logic                            alu_ack,
    input  logic [`VLEN+`V_ADDR_W+5:0]      alu_pay
);

    int fail_cnt = 0;   // read by the testbench at the end

    ////////////////////////////////////////////////////////////
    // four-phase rules on both peer links
    ////////////////////////////////////////////////////////////

    ld_ack_needs_req: assert property (@(posedge clk) disable iff (!nrst)
        $rose(ld_ack) |-> ld_req)
        else begin
            $error("loader ack rose without req");
            fail_cnt++;
        end

    alu_ack_needs_req: assert property (@(posedge clk) disable iff (!nrst)
        $rose(alu_ack) |-> alu_req)
        else begin
            $error("alu ack rose without req");
            fail_cnt++;
        end

    // payload frozen for as long as req stays up
    ld_pay_stable: assert property (@(posedge clk) disable iff (!nrst)
        (ld_req && $past(ld_req)) |-> $stable(ld_pay))
        else begin
            $error("loader payload moved under req");
            fail_cnt++;
        end

    alu_pay_stable: assert property (@(posedge clk) disable iff (!nrst)
        (alu_req && $past(alu_req)) |-> $stable(alu_pay))
        else begin
            $error("alu payload moved under req");
            fail_cnt++;
        end

    // owner gives the port back, ack falls once req is seen low
    ld_ack_drops: assert property (@(posedge clk) disable iff (!nrst)
        (ld_ack && !ld_req) |=> !ld_ack)
        else begin
            $error("loader ack stayed up after req fell");
            fail_cnt++;
        end

    alu_ack_drops: assert property (@(posedge clk) disable iff (!nrst)
        (alu_ack && !alu_req) |=> !alu_ack)
        else begin
            $error("alu ack stayed up after req fell");
            fail_cnt++;
        end

endmodule

bind vrf_arbiter vec_lane_props vec_lane_props_inst (
    .clk, .nrst,
    .ld_req (ld.req), .ld_ack (ld.ack), .ld_pay ({ld.kind, ld.addr, ld.idx, ld.data}),
    .alu_req (alu.req), .alu_ack (alu.ack),
    .alu_pay ({alu.kind, alu.addr, alu.idx, alu.data})
);

//--- verif/vec_lane_tb.sv
`timescale 1ns/1ps
`include "vec_settings.svh"

module vec_lane_tb import vec_pkg::*; ();

    localparam int N_GROUPS   = 6;     // group loads per load phase
    localparam int N_OPS      = 8;     // element ops per sew and phase
    localparam int HANDSHAKES = 2 * 4 * N_GROUPS + 7 * N_OPS;    // upper bound
    localparam int MAX_CYCLES = 12 * HANDSHAKES + 5 * 40 + 100;  // readbacks plus margin

    logic                   clk;
    logic                   nrst;
    sew_e                   sew;
    logic                   ld_req;
    logic                   ld_ack;
    logic                   ld_first;
    logic [`V_ADDR_W-1:0]   ld_reg;
    lmul_e                  ld_lmul;
    vreg_t                  ld_data;
    logic                   op_req;
    logic                   op_ack;
    alu_op_e                op_code;
    logic [`V_ADDR_W-1:0]   op_vd;
    logic [`V_ADDR_W-1:0]   op_vs1;
    logic [`V_ADDR_W-1:0]   op_vs2;
    logic [4:0]             op_idx;
    logic                   op_masked;
    logic [`V_ADDR_W-1:0]   rd_reg;
    vreg_t                  rd_data;

    vreg_t  model [`V_REGS];        // expected register file
    sew_e   cur_sew;                // sew as the model sees it, no nba lag
    int     seed = 32'h3fd0_23e4;
    int     cycles = 0;
    int     reg_errs = 0;
    int     elem_errs = 0;
    int     idle_errs = 0;
    int     timeout_errs = 0;

    vec_lane_top vec_lane_top_inst (
        .clk, .nrst, .sew, .ld_req, .ld_ack, .ld_first, .ld_reg, .ld_lmul, .ld_data,
        .op_req, .op_ack, .op_code, .op_vd, .op_vs1, .op_vs2, .op_idx, .op_masked,
        .rd_reg, .rd_data
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    ////////////////////////////////////////////////////////////
    // reference model helpers
    ////////////////////////////////////////////////////////////

    function automatic int elem_bits(sew_e s);
        case (s)
            sew_8:   return 8;
            sew_16:  return 16;
            default: return 32;
        endcase
    endfunction

    function automatic elem_t get_elem(vreg_t r, sew_e s, logic [4:0] idx);
        logic [6:0] lsb;
        lsb = 7'(int'(idx) * elem_bits(s));     // idx always in range here
        case (s)
            sew_8:   return {24'h0, r[lsb +: 8]};
            sew_16:  return {16'h0, r[lsb +: 16]};
            default: return r[lsb +: 32];
        endcase
    endfunction

    function automatic vreg_t put_elem(vreg_t r, sew_e s, logic [4:0] idx, elem_t v);
        vreg_t      o;
        logic [6:0] lsb;
        o   = r;
        lsb = 7'(int'(idx) * elem_bits(s));
        case (s)
            sew_8:   o[lsb +: 8]  = v[7:0];
            sew_16:  o[lsb +: 16] = v[15:0];
            default: o[lsb +: 32] = v;
        endcase
        return o;
    endfunction

    function automatic elem_t alu_model(alu_op_e op, elem_t a, elem_t b, sew_e s);
        elem_t full;
        case (op)
            op_add:  full = a + b;
            op_sub:  full = a - b;
            op_and:  full = a & b;
            op_or:   full = a | b;
            op_xor:  full = a ^ b;
            op_min:  full = (a < b) ? a : b;
            default: full = '0;
        endcase
        return get_elem(vreg_t'(full), s, 5'd0);   // element 0 = low sew bits
    endfunction

    function automatic vreg_t rand_vreg();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // base inside [lo, lo+span), aligned to the group size
    function automatic logic [4:0] aligned_base(lmul_e m, int lo, int span);
        int size;
        size = 1 << int'(m);
        return 5'(lo + (({$random(seed)} % span) & ~(size - 1)));
    endfunction

    function automatic int total_errors();
        return reg_errs + elem_errs + idle_errs + timeout_errs
             + vec_lane_top_inst.vrf_arbiter_inst.vec_lane_props_inst.fail_cnt;
    endfunction

    ////////////////////////////////////////////////////////////
    // compares and readback
    ////////////////////////////////////////////////////////////

    task automatic check_reg(input string name, input int r, input vreg_t exp, input vreg_t act);
        if (act !== exp) begin
            reg_errs++;
            $display("ERR %s v%0d: expected %h, actual %h", name, r, exp, act);
        end
    endtask

    task automatic check_elem(input string name, input elem_t exp, input elem_t act);
        if (act !== exp) begin
            elem_errs++;
            $display("ERR %s element: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_all(input string name);
        rd_reg <= '0;
        for (int i = 0; i < `V_REGS; i++) begin
            @(posedge clk);                     // rd_data of the previous cycle
            check_reg(name, i, model[i], rd_data);
            rd_reg <= 5'(i + 1);
        end
    endtask

    task automatic report_counts();
        $display("errors: reg %0d elem %0d handshake %0d timeout %0d assert %0d",
                 reg_errs, elem_errs, idle_errs, timeout_errs,
                 vec_lane_top_inst.vrf_arbiter_inst.vec_lane_props_inst.fail_cnt);
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic load_group(input lmul_e m, input logic [4:0] base);
        vreg_t d;
        for (int n = 0; n < (1 << int'(m)); n++) begin
            d = rand_vreg();
            ld_first <= (n == 0);
            ld_reg   <= base;
            ld_lmul  <= m;
            ld_data  <= d;
            ld_req   <= 1'b1;
            do @(posedge clk); while (!ld_ack);
            model[base + 5'(n)] = d;            // beat n lands in base+n
            ld_req <= 1'b0;
            do @(posedge clk); while (ld_ack);
        end
    endtask

    task automatic run_op(input string name, input logic [4:0] vd, input logic [4:0] vs1,
                          input logic [4:0] vs2, input logic masked);
        alu_op_e    code;
        logic [4:0] idx;
        elem_t      res;
        logic       en;
        code = alu_op_e'(3'({$random(seed)} % 6));
        idx  = 5'({$random(seed)} % (128 / elem_bits(cur_sew)));
        res  = alu_model(code, get_elem(model[vs1], cur_sew, idx),
                         get_elem(model[vs2], cur_sew, idx), cur_sew);
        en   = !masked || model[0][idx];        // v0 bit gates the write
        op_code   <= code;
        op_vd     <= vd;
        op_vs1    <= vs1;
        op_vs2    <= vs2;
        op_idx    <= idx;
        op_masked <= masked;
        op_req    <= 1'b1;
        do @(posedge clk); while (!op_ack);
        if (en) model[vd] = put_elem(model[vd], cur_sew, idx, res);
        op_req <= 1'b0;
        do @(posedge clk); while (op_ack);
        rd_reg <= vd;
        @(posedge clk);
        check_elem(name, get_elem(model[vd], cur_sew, idx), get_elem(rd_data, cur_sew, idx));
    endtask

    initial begin
        lmul_e m;
        string tag;
        nrst = 1'b0;
        sew = sew_8;
        cur_sew = sew_8;
        ld_req = 1'b0;
        ld_first = 1'b0;
        ld_reg = '0;
        ld_lmul = lmul_1;
        ld_data = '0;
        op_req = 1'b0;
        op_code = op_add;
        op_vd = '0;
        op_vs1 = '0;
        op_vs2 = '0;
        op_idx = '0;
        op_masked = 1'b0;
        rd_reg = '0;
        for (int i = 0; i < `V_REGS; i++) model[i] = '0;
        repeat (2) @(posedge clk);
        nrst <= 1'b1;
        check_all("reset");

        for (int g = 0; g < N_GROUPS; g++) begin   // lmul 1, 2, 4 in turn
            m = lmul_e'(2'(g % 3));
            load_group(m, aligned_base(m, 0, 32));
        end
        check_all("load");

        for (int pass = 0; pass < 2; pass++) begin // unmasked, then masked
            if (pass == 0) tag = "op";
            else tag = "masked";
            if (pass == 1) load_group(lmul_1, 5'd0);   // random mask bits in v0, ones and zeros
            for (int s = 0; s < 3; s++) begin
                cur_sew = sew_e'(2'(s));
                sew <= cur_sew;                     // both req low here
                for (int k = 0; k < N_OPS; k++) begin
                    run_op(tag, 5'($random(seed)), 5'($random(seed)), 5'($random(seed)),
                           pass == 1);
                end
            end
            check_all(tag);
        end

        // loads on v8..v15 race ops on v16..v31 for the write port
        cur_sew = sew_e'(2'({$random(seed)} % 3));
        sew <= cur_sew;
        fork
            for (int g = 0; g < N_GROUPS; g++) begin
                load_group(lmul_e'(2'(g % 3)), aligned_base(lmul_e'(2'(g % 3)), 8, 8));
            end
            for (int k = 0; k < N_OPS; k++) begin
                run_op("concurrent", 5'(16 + {$random(seed)} % 16),
                       5'(16 + {$random(seed)} % 16), 5'(16 + {$random(seed)} % 16),
                       1'($random(seed)));
            end
        join
        if (ld_ack || op_ack) begin
            idle_errs++;
            $display("handshakes did not return to idle after the concurrent phase");
        end
        check_all("concurrent");

        report_counts();
        if (total_errors() == 0) $display("test passed");
        else $display("test failed");
        $finish;
    end

    // watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            timeout_errs = timeout_errs + 1;
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            report_counts();
            $display("test failed");
            $finish;
        end
    end

endmodule

//--- vec_lane.f
+incdir+src
src/vec_pkg.sv
src/vrf_wr_if.sv
src/v_regfile.sv
src/vrf_arbiter.sv
src/vec_loader.sv
src/vec_elem_alu.sv
src/vec_lane_top.sv
verif/vec_lane_props.sv
verif/vec_lane_tb.sv

//--- Makefile
TOP := vec_lane_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vec_lane.f --top-module $(TOP)

obj_dir/V$(TOP): vec_lane.f $(wildcard src/*.sv src/*.svh verif/*.sv)
	verilator --binary --assert -j 0 -f vec_lane.f --top-module $(TOP)

# the run keeps going past assertion errors so the testbench can report them
sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1
	cat sim.log
	@if grep -q "test failed" sim.log; then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "test passed" sim.log; then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
